/* dv/lsu_vectors.txt */
// kind pipe_mask addr data strobe size expect
// kind 0 write, 1 read, 2 dual write, 3 stall burst; expect is first pipe or store count
0 1 00001000 11112222 f 2 0
0 2 00001004 33334444 3 1 1
0 1 00001008 000000a5 1 0 0
1 1 00002000 00000000 0 2 0
2 3 00003000 cafe0001 f 2 0
1 2 00002004 00000000 0 2 1
1 3 00004000 00000000 0 1 0
3 1 00005000 55550000 f 2 4
0 2 0000100c 00006666 3 1 1
1 1 00002008 00000000 0 2 0
2 3 00003010 deadbeef f 2 0
0 1 00001010 77777777 f 2 0
0 1 00001014 88888888 c 1 0
0 2 00001018 99999999 f 2 1
1 3 00004010 00000000 0 2 0
3 1 00005100 12340000 f 2 4
1 2 0000200c 00000000 0 0 1
0 1 00001020 abcdef01 f 2 0
2 3 00003020 0f0f0f0f f 2 0
1 1 00002010 00000000 0 2 0

/* sim.f */
+incdir+common
common/lsu_pkg.sv
hw/lsu_req_merge.sv
write_buf/lsu_write_buf.sv
hw/lsu_bus_seq.sv
hw/lsu_uncached_port.sv
dv/tb_lsu_uncached_port.sv

/* Bender.yml */
package:
  name: lsu_uncached_port

sources:
  - include_dirs:
      - common
    files:
      - common/lsu_pkg.sv
      - hw/lsu_req_merge.sv
      - write_buf/lsu_write_buf.sv
      - hw/lsu_bus_seq.sv
      - hw/lsu_uncached_port.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_lsu_uncached_port.sv

/* dv/tb_lsu_uncached_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module tb_lsu_uncached_port
  import lsu_pkg::*;
();

  localparam int VEC_FIELDS = 7;
  localparam int MAX_VEC = 32;
  localparam logic [31:0] RD_XOR = 32'h5a5a_a5a5;
  localparam logic [31:0] SEED = 32'hf6ae;

  logic clk;
  logic rst_n;
  logic [`LSU_PIPE_CNT-1:0] wr_valid_i;
  logic [`LSU_PIPE_CNT-1:0][`LSU_ADDR_W-1:0] wr_addr_i;
  logic [`LSU_PIPE_CNT-1:0][`LSU_DATA_W-1:0] wr_data_i;
  logic [`LSU_PIPE_CNT-1:0][`LSU_STRB_W-1:0] wr_strobe_i;
  acc_size_e [`LSU_PIPE_CNT-1:0] wr_size_i;
  logic [`LSU_PIPE_CNT-1:0] wr_ready_o;
  logic [`LSU_PIPE_CNT-1:0] rd_valid_i;
  logic [`LSU_PIPE_CNT-1:0][`LSU_ADDR_W-1:0] rd_addr_i;
  acc_size_e [`LSU_PIPE_CNT-1:0] rd_size_i;
  logic [`LSU_PIPE_CNT-1:0] rd_done_o;
  logic [`LSU_DATA_W-1:0] rd_data_o;
  logic bus_valid_o;
  logic bus_write_o;
  logic [`LSU_ADDR_W-1:0] bus_addr_o;
  acc_size_e bus_size_o;
  logic bus_wvalid_o;
  logic bus_wlast_o;
  logic [`LSU_DATA_W-1:0] bus_wdata_o;
  logic [`LSU_STRB_W-1:0] bus_wstrobe_o;
  logic bus_ready_i;
  logic bus_data_ok_i;
  logic bus_data_last_i;
  logic [`LSU_DATA_W-1:0] bus_rdata_i;

  logic [31:0] vec_mem [0:VEC_FIELDS*MAX_VEC-1];
  logic [69:0] exp_q [$];
  logic [33:0] rd_exp_q [$];
  logic [`LSU_ADDR_W-1:0] aw_addr;
  acc_size_e aw_size;
  logic stall;
  logic ok_draw;
  logic full_exp;
  int acc_cnt;
  int pop_cnt;
  int num_vec;
  int cycle_cnt;
  int cycle_limit;

  always #4 clk = ~clk;

  lsu_uncached_port u_dut (.*);

  task automatic check_equal(input logic [71:0] got, input logic [71:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s (got %0h, expected %0h)", $time, what, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "first mismatch ends the run");
    end
  endtask

  function automatic logic [31:0] addr_for_pipe(input logic [31:0] base, input int p);
    return base + 32'h100 * p;
  endfunction

  function automatic logic [31:0] data_for_pipe(input logic [31:0] d, input int p);
    return (p == 0) ? d : ~d;
  endfunction

  // bus responder with random stalls on both phases
  always @(posedge clk) begin
    ok_draw = ($urandom % 3) != 0;
    bus_ready_i     <= !stall && (($urandom % 3) != 0);
    bus_data_ok_i   <= ok_draw;
    bus_data_last_i <= ok_draw;
    if (bus_valid_o && bus_ready_i && !bus_write_o) begin
      bus_rdata_i <= bus_addr_o ^ RD_XOR;
    end
  end

  // handshakes complete at the next rising edge
  always @(negedge clk) begin
    if (rst_n) begin
      full_exp = (acc_cnt - pop_cnt) == `LSU_WBUF_DEPTH;
      check_equal(wr_ready_o, {!full_exp && !wr_valid_i[0], !full_exp},
                  "wr_ready does not follow buffer fill and pipe priority");
      check_equal(rd_done_o & ~rd_valid_i, 0, "read done without a read request");
      for (int p = 0; p < `LSU_PIPE_CNT; p++) begin
        if (wr_valid_i[p] && wr_ready_o[p]) begin
          exp_q.push_back({wr_addr_i[p], wr_data_i[p], wr_strobe_i[p], wr_size_i[p]});
          acc_cnt = acc_cnt + 1;
        end
      end
      if (bus_valid_o && bus_ready_i) begin
        if (bus_write_o) begin
          aw_addr = bus_addr_o;
          aw_size = bus_size_o;
        end else begin
          check_equal(exp_q.size(), 0, "read reached the bus before earlier stores drained");
          check_equal(rd_exp_q.size() > 0, 1'b1, "read on the bus that no pipe asked for");
          check_equal({bus_addr_o, bus_size_o}, rd_exp_q.pop_front(),
                      "read address and size on the bus");
        end
      end
      if (bus_wvalid_o && bus_data_ok_i) begin
        check_equal(bus_wlast_o, 1'b1, "wlast low in a single-beat write");
        check_equal(exp_q.size() > 0, 1'b1, "bus write with no accepted store left");
        check_equal({aw_addr, bus_wdata_o, bus_wstrobe_o, aw_size}, exp_q.pop_front(),
                    "bus write differs from the next accepted store");
        $display("bus write addr %h data %h strobe %h size %0d",
                 aw_addr, bus_wdata_o, bus_wstrobe_o, aw_size);
        pop_cnt = pop_cnt + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("run did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end
  end

  task automatic wait_drain();
    @(posedge clk);
    while (acc_cnt != pop_cnt) begin
      @(posedge clk);
    end
  endtask

  task automatic offer_stores(input logic [1:0] mask, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] strobe,
                              input acc_size_e size, input int first_pipe);
    logic [1:0] left;
    logic [1:0] taken;
    left = mask;
    @(posedge clk);
    for (int p = 0; p < `LSU_PIPE_CNT; p++) begin
      if (mask[p]) begin
        wr_valid_i[p]  <= 1'b1;
        wr_addr_i[p]   <= addr_for_pipe(addr, p);
        wr_data_i[p]   <= data_for_pipe(data, p);
        wr_strobe_i[p] <= strobe;
        wr_size_i[p]   <= size;
      end
    end
    while (left != 0) begin
      @(negedge clk);
      taken = left & wr_ready_o;
      if (taken != 0 && left == mask) begin
        check_equal(taken, 2'b01 << first_pipe, "wrong pipe store taken first");
      end
      @(posedge clk);
      for (int p = 0; p < `LSU_PIPE_CNT; p++) begin
        if (taken[p]) begin
          wr_valid_i[p] <= 1'b0;
        end
      end
      left = left & ~taken;
    end
  endtask

  task automatic issue_reads(input logic [1:0] mask, input logic [31:0] addr,
                             input acc_size_e size, input int first_pipe);
    logic [1:0] left;
    logic [1:0] exp_done;
    int order;
    int p;
    left = mask;
    order = 0;
    @(posedge clk);
    for (int i = 0; i < `LSU_PIPE_CNT; i++) begin
      if (mask[i]) begin
        rd_valid_i[i] <= 1'b1;
        rd_addr_i[i]  <= addr_for_pipe(addr, i);
        rd_size_i[i]  <= size;
        rd_exp_q.push_back({addr_for_pipe(addr, i), size});
      end
    end
    while (left != 0) begin
      @(negedge clk);
      if (rd_done_o != 0) begin
        exp_done = (order == 0) ? (2'b01 << first_pipe) : left;
        check_equal(rd_done_o, exp_done, "read done on the wrong pipe");
        p = exp_done[1] ? 1 : 0;
        check_equal(rd_data_o, addr_for_pipe(addr, p) ^ RD_XOR, "read data");
        order = order + 1;
        @(posedge clk);
        rd_valid_i[p] <= 1'b0;
        left[p] = 1'b0;
      end
    end
  endtask

  // bus held off while the buffer fills to its depth
  task automatic fill_while_stalled(input logic [31:0] addr, input logic [31:0] data,
                                    input logic [3:0] strobe, input acc_size_e size,
                                    input int exp_cnt);
    int taken;
    logic last_ready;
    taken = 0;
    wait_drain();
    stall <= 1'b1;
    @(posedge clk);
    wr_valid_i[0]  <= 1'b1;
    wr_addr_i[0]   <= addr;
    wr_data_i[0]   <= data;
    wr_strobe_i[0] <= strobe;
    wr_size_i[0]   <= size;
    repeat (exp_cnt + 4) begin
      @(negedge clk);
      last_ready = wr_ready_o[0];
      if (last_ready) begin
        taken = taken + 1;
      end
      @(posedge clk);
      wr_addr_i[0] <= addr + 32'd4 * taken;
      wr_data_i[0] <= data + taken;
    end
    check_equal(taken, exp_cnt, "stores accepted while the bus is stalled");
    check_equal(last_ready, 1'b0, "wr_ready still high with the buffer full");
    wr_valid_i[0] <= 1'b0;
    stall <= 1'b0;
    wait_drain();
  endtask

  task automatic apply_vector(input int v);
    int b;
    logic [1:0] mask;
    acc_size_e size;
    b = v * VEC_FIELDS;
    mask = vec_mem[b + 1][1:0];
    size = acc_size_e'(vec_mem[b + 5][1:0]);
    case (vec_mem[b])
      32'd0, 32'd2: offer_stores(mask, vec_mem[b + 2], vec_mem[b + 3], vec_mem[b + 4][3:0],
                                 size, vec_mem[b + 6]);
      32'd1: issue_reads(mask, vec_mem[b + 2], size, vec_mem[b + 6]);
      32'd3: fill_while_stalled(vec_mem[b + 2], vec_mem[b + 3], vec_mem[b + 4][3:0],
                                size, vec_mem[b + 6]);
      default: begin
        $display("vector %0d has an unknown operation kind %0h", v, vec_mem[b]);
        $display("ERRORS FOUND");
        $fatal(1, "bad vector");
      end
    endcase
  endtask

  initial begin
    void'($urandom(SEED));
    clk = 1'b0;
    rst_n = 1'b0;
    wr_valid_i = '0;
    wr_addr_i = '0;
    wr_data_i = '0;
    wr_strobe_i = '0;
    rd_valid_i = '0;
    rd_addr_i = '0;
    for (int p = 0; p < `LSU_PIPE_CNT; p++) begin
      wr_size_i[p] = SIZE_WORD;
      rd_size_i[p] = SIZE_WORD;
    end
    bus_ready_i = 1'b0;
    bus_data_ok_i = 1'b0;
    bus_data_last_i = 1'b0;
    bus_rdata_i = '0;
    stall = 1'b0;
    acc_cnt = 0;
    pop_cnt = 0;
    cycle_cnt = 0;
    $readmemh("dv/lsu_vectors.txt", vec_mem);
    num_vec = 0;
    for (int i = 0; i < MAX_VEC; i++) begin
      if (!$isunknown(vec_mem[i * VEC_FIELDS])) begin
        num_vec = i + 1;
      end
    end
    if (num_vec == 0) begin
      $display("no vectors could be read from dv/lsu_vectors.txt");
      $display("ERRORS FOUND");
      $fatal(1, "empty vector file");
    end
    cycle_limit = 64 * num_vec + 200;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_equal(wr_ready_o, 2'b11, "wr_ready after reset");
    check_equal({bus_valid_o, bus_wvalid_o}, 2'b00, "bus strobes after reset");
    check_equal(rd_done_o, 2'b00, "rd_done after reset");
    check_equal(u_dut.u_bus_seq.state_q, SEQ_IDLE, "sequencer state after reset");
    for (int v = 0; v < num_vec; v++) begin
      apply_vector(v);
    end
    wait_drain();
    check_equal(rd_exp_q.size(), 0, "reads left that never reached the bus");
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/lsu_uncached_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_uncached_port import lsu_pkg::*; (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [`LSU_PIPE_CNT-1:0]                 wr_valid_i,
  input  logic [`LSU_PIPE_CNT-1:0][`LSU_ADDR_W-1:0] wr_addr_i,
  input  logic [`LSU_PIPE_CNT-1:0][`LSU_DATA_W-1:0] wr_data_i,
  input  logic [`LSU_PIPE_CNT-1:0][`LSU_STRB_W-1:0] wr_strobe_i,
  input  acc_size_e [`LSU_PIPE_CNT-1:0]            wr_size_i,
  output logic [`LSU_PIPE_CNT-1:0]                 wr_ready_o,
  input  logic [`LSU_PIPE_CNT-1:0]                 rd_valid_i,
  input  logic [`LSU_PIPE_CNT-1:0][`LSU_ADDR_W-1:0] rd_addr_i,
  input  acc_size_e [`LSU_PIPE_CNT-1:0]            rd_size_i,
  output logic [`LSU_PIPE_CNT-1:0]                 rd_done_o,
  output logic [`LSU_DATA_W-1:0]                   rd_data_o,
  output logic                                     bus_valid_o,
  output logic                                     bus_write_o,
  output logic [`LSU_ADDR_W-1:0]                   bus_addr_o,
  output acc_size_e                                bus_size_o,
  output logic                                     bus_wvalid_o,
  output logic                                     bus_wlast_o,
  output logic [`LSU_DATA_W-1:0]                   bus_wdata_o,
  output logic [`LSU_STRB_W-1:0]                   bus_wstrobe_o,
  input  logic                                     bus_ready_i,
  input  logic                                     bus_data_ok_i,
  input  logic                                     bus_data_last_i,
  input  logic [`LSU_DATA_W-1:0]                   bus_rdata_i
);

  logic                   wbuf_push;
  wbuf_entry_t            wbuf_entry;
  logic                   wbuf_full;
  logic                   wbuf_empty;
  wbuf_entry_t            wbuf_head;
  logic                   wbuf_pop;
  logic                   rd_pending;
  logic [`LSU_ADDR_W-1:0] rd_addr;
  acc_size_e              rd_size;
  logic                   seq_rd_done;

  lsu_req_merge u_req_merge (
    .clk           (clk),
    .rst_n         (rst_n),
    .wr_valid_i    (wr_valid_i),
    .wr_addr_i     (wr_addr_i),
    .wr_data_i     (wr_data_i),
    .wr_strobe_i   (wr_strobe_i),
    .wr_size_i     (wr_size_i),
    .rd_valid_i    (rd_valid_i),
    .rd_addr_i     (rd_addr_i),
    .rd_size_i     (rd_size_i),
    .wbuf_full_i   (wbuf_full),
    .seq_rd_done_i (seq_rd_done),
    .wr_ready_o    (wr_ready_o),
    .wbuf_push_o   (wbuf_push),
    .wbuf_entry_o  (wbuf_entry),
    .rd_pending_o  (rd_pending),
    .rd_addr_o     (rd_addr),
    .rd_size_o     (rd_size),
    .rd_done_o     (rd_done_o)
  );

  lsu_write_buf u_write_buf (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (wbuf_push),
    .entry_i (wbuf_entry),
    .pop_i   (wbuf_pop),
    .head_o  (wbuf_head),
    .empty_o (wbuf_empty),
    .full_o  (wbuf_full)
  );

  lsu_bus_seq u_bus_seq (
    .clk             (clk),
    .rst_n           (rst_n),
    .wbuf_empty_i    (wbuf_empty),
    .wbuf_head_i     (wbuf_head),
    .rd_pending_i    (rd_pending),
    .rd_addr_i       (rd_addr),
    .rd_size_i       (rd_size),
    .bus_ready_i     (bus_ready_i),
    .bus_data_ok_i   (bus_data_ok_i),
    .bus_data_last_i (bus_data_last_i),
    .bus_rdata_i     (bus_rdata_i),
    .wbuf_pop_o      (wbuf_pop),
    .rd_done_o       (seq_rd_done),
    .rd_data_o       (rd_data_o),
    .bus_valid_o     (bus_valid_o),
    .bus_write_o     (bus_write_o),
    .bus_addr_o      (bus_addr_o),
    .bus_size_o      (bus_size_o),
    .bus_wvalid_o    (bus_wvalid_o),
    .bus_wlast_o     (bus_wlast_o),
    .bus_wdata_o     (bus_wdata_o),
    .bus_wstrobe_o   (bus_wstrobe_o)
  );

endmodule

`default_nettype wire

/* hw/lsu_bus_seq.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_bus_seq import lsu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wbuf_empty_i,
  input  wbuf_entry_t            wbuf_head_i,
  input  logic                   rd_pending_i,
  input  logic [`LSU_ADDR_W-1:0] rd_addr_i,
  input  acc_size_e              rd_size_i,
  input  logic                   bus_ready_i,
  input  logic                   bus_data_ok_i,
  input  logic                   bus_data_last_i,
  input  logic [`LSU_DATA_W-1:0] bus_rdata_i,
  output logic                   wbuf_pop_o,
  output logic                   rd_done_o,
  output logic [`LSU_DATA_W-1:0] rd_data_o,
  output logic                   bus_valid_o,
  output logic                   bus_write_o,
  output logic [`LSU_ADDR_W-1:0] bus_addr_o,
  output acc_size_e              bus_size_o,
  output logic                   bus_wvalid_o,
  output logic                   bus_wlast_o,
  output logic [`LSU_DATA_W-1:0] bus_wdata_o,
  output logic [`LSU_STRB_W-1:0] bus_wstrobe_o
);

  seq_state_e state_q;
  seq_state_e state_d;
  logic       wr_phase;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= SEQ_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d    = state_q;
    wbuf_pop_o = 1'b0;
    rd_done_o  = 1'b0;
    case (state_q)
      SEQ_IDLE: begin
        // stores go first so a read never passes one
        if (!wbuf_empty_i) begin
          state_d = SEQ_WR_ADDR;
        end else if (rd_pending_i) begin
          state_d = SEQ_RD_ADDR;
        end
      end
      SEQ_WR_ADDR: begin
        if (bus_ready_i) begin
          state_d = SEQ_WR_DATA;
        end
      end
      SEQ_WR_DATA: begin
        if (bus_data_ok_i) begin
          wbuf_pop_o = 1'b1;
          state_d    = SEQ_IDLE;
        end
      end
      SEQ_RD_ADDR: begin
        if (bus_ready_i) begin
          state_d = SEQ_RD_DATA;
        end
      end
      SEQ_RD_DATA: begin
        if (bus_data_ok_i && bus_data_last_i) begin
          rd_done_o = 1'b1;
          state_d   = SEQ_IDLE;
        end
      end
      default: begin
        state_d = SEQ_IDLE;
      end
    endcase
  end

  assign wr_phase = (state_q == SEQ_WR_ADDR) || (state_q == SEQ_WR_DATA);

  // address phase fields
  assign bus_valid_o = (state_q == SEQ_WR_ADDR) || (state_q == SEQ_RD_ADDR);
  assign bus_write_o = (state_q == SEQ_WR_ADDR);
  assign bus_addr_o  = wr_phase ? wbuf_head_i.addr : rd_addr_i;
  assign bus_size_o  = wr_phase ? wbuf_head_i.size : rd_size_i;

  // single beat, so wlast rides with wvalid
  assign bus_wvalid_o  = (state_q == SEQ_WR_DATA);
  assign bus_wlast_o   = (state_q == SEQ_WR_DATA);
  assign bus_wdata_o   = wbuf_head_i.data;
  assign bus_wstrobe_o = wbuf_head_i.strobe;

  assign rd_data_o = bus_rdata_i;

endmodule

`default_nettype wire

/* write_buf/lsu_write_buf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_write_buf import lsu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        push_i,
  input  wbuf_entry_t entry_i,
  input  logic        pop_i,
  output wbuf_entry_t head_o,
  output logic        empty_o,
  output logic        full_o
);

  localparam int IDX_W = $clog2(`LSU_WBUF_DEPTH);
  localparam int PTR_W = IDX_W + 1;
  localparam logic [PTR_W-1:0] LAST_CNT = PTR_W'(`LSU_WBUF_DEPTH - 1);

  wbuf_entry_t      mem [`LSU_WBUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] count;
  logic             empty_q;
  logic             full_q;
  logic             do_push;
  logic             do_pop;

  // extra pointer bit keeps full and empty apart
  assign count   = wr_ptr_q - rd_ptr_q;
  assign do_push = push_i && !full_q;
  assign do_pop  = pop_i && !empty_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
    end else if (do_push) begin
      wr_ptr_q <= wr_ptr_q + PTR_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
    end else if (do_pop) begin
      rd_ptr_q <= rd_ptr_q + PTR_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q[IDX_W-1:0]] <= entry_i;
    end
  end

  // flags follow from push, pop and the current count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      empty_q <= 1'b1;
    end else if (empty_q) begin
      if (do_push) begin
        empty_q <= 1'b0;
      end
    end else if (do_pop && !do_push && (count == PTR_W'(1))) begin
      empty_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      if (do_pop && !do_push) begin
        full_q <= 1'b0;
      end
    end else if (do_push && !do_pop && (count == LAST_CNT)) begin
      full_q <= 1'b1;
    end
  end

  assign head_o  = mem[rd_ptr_q[IDX_W-1:0]];
  assign empty_o = empty_q;
  assign full_o  = full_q;

endmodule

`default_nettype wire

/* hw/lsu_req_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_req_merge import lsu_pkg::*; (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic [`LSU_PIPE_CNT-1:0]                 wr_valid_i,
  input  logic [`LSU_PIPE_CNT-1:0][`LSU_ADDR_W-1:0] wr_addr_i,
  input  logic [`LSU_PIPE_CNT-1:0][`LSU_DATA_W-1:0] wr_data_i,
  input  logic [`LSU_PIPE_CNT-1:0][`LSU_STRB_W-1:0] wr_strobe_i,
  input  acc_size_e [`LSU_PIPE_CNT-1:0]            wr_size_i,
  input  logic [`LSU_PIPE_CNT-1:0]                 rd_valid_i,
  input  logic [`LSU_PIPE_CNT-1:0][`LSU_ADDR_W-1:0] rd_addr_i,
  input  acc_size_e [`LSU_PIPE_CNT-1:0]            rd_size_i,
  input  logic                                     wbuf_full_i,
  input  logic                                     seq_rd_done_i,
  output logic [`LSU_PIPE_CNT-1:0]                 wr_ready_o,
  output logic                                     wbuf_push_o,
  output wbuf_entry_t                              wbuf_entry_o,
  output logic                                     rd_pending_o,
  output logic [`LSU_ADDR_W-1:0]                   rd_addr_o,
  output acc_size_e                                rd_size_o,
  output logic [`LSU_PIPE_CNT-1:0]                 rd_done_o
);

  localparam int SRC_W = (`LSU_PIPE_CNT > 1) ? $clog2(`LSU_PIPE_CNT) : 1;

  logic             wr_blocked;
  logic [SRC_W-1:0] rd_pick;
  logic [SRC_W-1:0] rd_src_q;
  logic             rd_pend_q;
  logic [`LSU_ADDR_W-1:0] rd_addr_q;
  acc_size_e        rd_size_q;

  // lowest pipe wins, higher pipes see ready drop
  always_comb begin
    wbuf_entry_o = '0;
    wr_blocked   = wbuf_full_i;
    for (int p = `LSU_PIPE_CNT - 1; p >= 0; p--) begin
      if (wr_valid_i[p]) begin
        wbuf_entry_o.addr   = wr_addr_i[p];
        wbuf_entry_o.data   = wr_data_i[p];
        wbuf_entry_o.strobe = wr_strobe_i[p];
        wbuf_entry_o.size   = wr_size_i[p];
      end
    end
    for (int p = 0; p < `LSU_PIPE_CNT; p++) begin
      wr_ready_o[p] = !wr_blocked;
      wr_blocked    = wr_blocked | wr_valid_i[p];
    end
  end

  assign wbuf_push_o = (|wr_valid_i) && !wbuf_full_i;

  always_comb begin
    rd_pick = '0;
    for (int p = `LSU_PIPE_CNT - 1; p >= 0; p--) begin
      if (rd_valid_i[p]) begin
        rd_pick = SRC_W'(p);
      end
    end
  end

  // single outstanding read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pend_q <= 1'b0;
      rd_src_q  <= '0;
    end else if (rd_pend_q) begin
      if (seq_rd_done_i) begin
        rd_pend_q <= 1'b0;
      end
    end else if (|rd_valid_i) begin
      rd_pend_q <= 1'b1;
      rd_src_q  <= rd_pick;
    end
  end

  always_ff @(posedge clk) begin
    if (!rd_pend_q && (|rd_valid_i)) begin
      rd_addr_q <= rd_addr_i[rd_pick];
      rd_size_q <= rd_size_i[rd_pick];
    end
  end

  assign rd_pending_o = rd_pend_q;
  assign rd_addr_o    = rd_addr_q;
  assign rd_size_o    = rd_size_q;

  // steer the done pulse back to the captured pipe
  always_comb begin
    for (int p = 0; p < `LSU_PIPE_CNT; p++) begin
      rd_done_o[p] = seq_rd_done_i && (rd_src_q == SRC_W'(p));
    end
  end

endmodule

`default_nettype wire

/* common/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  `include "lsu_defs.svh"

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } acc_size_e;

  typedef enum logic [2:0] {
    SEQ_IDLE    = 3'd0,
    SEQ_WR_ADDR = 3'd1,
    SEQ_WR_DATA = 3'd2,
    SEQ_RD_ADDR = 3'd3,
    SEQ_RD_DATA = 3'd4
  } seq_state_e;

  // one posted store, 70 bits
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_DATA_W-1:0] data;
    logic [`LSU_STRB_W-1:0] strobe;
    acc_size_e              size;
  } wbuf_entry_t;

endpackage

`default_nettype wire

/* common/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// load/store pipes feeding the uncached port
`define LSU_PIPE_CNT 2

// bus widths
`define LSU_ADDR_W 32
`define LSU_DATA_W 32
`define LSU_STRB_W 4

// posted write buffer entries
`define LSU_WBUF_DEPTH 4

`endif
